// ==== verilog/spmm_pkg.sv ====
`default_nettype none

package spmm_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////
  localparam int DATA_WIDTH    = 8;
  localparam int H_ROWS        = 5;
  localparam int DOT_SIZE      = 5;
  localparam int W_COLS        = 3;
  localparam int NNZ_MAX       = 8;
  // result buffer depth
  localparam int OUT_DEPTH     = 2;

  // widths
  localparam int COL_IDX_WIDTH = 3;
  localparam int ROW_LEN_WIDTH = 3;
  localparam int ROW_IDX_WIDTH = 3;
  // 16 bit products, 5 terms
  localparam int ACC_WIDTH     = 19;

  ////////////////////////////////////////////////////////////
  // packed types
  ////////////////////////////////////////////////////////////
  // one nonzero, payload of a row fifo
  typedef struct packed {
    logic [COL_IDX_WIDTH-1:0] col;
    logic [DATA_WIDTH-1:0]    value;
  } h_entry_t;

  // per row info, flag in the lsb
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0] row_len;
    logic                     flag;
  } node_info_t;

  // one product row
  typedef struct packed {
    logic [ROW_IDX_WIDTH-1:0]         row;
    logic [W_COLS-1:0][ACC_WIDTH-1:0] acc;
    logic                             last;
  } row_result_t;

  // row search result
  typedef struct packed {
    logic                     found;
    logic [ROW_IDX_WIDTH-1:0] row;
  } row_pick_t;

  // batch arrays
  typedef logic [NNZ_MAX-1:0][COL_IDX_WIDTH-1:0]           col_idx_array_t;
  typedef logic [NNZ_MAX-1:0][DATA_WIDTH-1:0]              value_array_t;
  typedef node_info_t [H_ROWS-1:0]                         node_info_array_t;
  typedef logic [DOT_SIZE-1:0][W_COLS-1:0][DATA_WIDTH-1:0] weight_array_t;

  // first flagged row at or above from
  // skip_empty also passes over rows of length zero
  function automatic row_pick_t find_row(
    input node_info_array_t         info,
    input logic [ROW_IDX_WIDTH-1:0] from,
    input logic                     skip_empty
  );
    row_pick_t pick;
    pick = '0;
    // walk downward so the lowest match wins
    for (int r = H_ROWS - 1; r >= 0; r--) begin
      if (r >= from && info[r].flag && !(skip_empty && info[r].row_len == '0)) begin
        pick.found = 1'b1;
        pick.row   = ROW_IDX_WIDTH'(r);
      end
    end
    return pick;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire      clk,
  input  wire      rst_i,
  input  wire      wr_en_i,
  input  wire      payload_t wr_data_i,
  input  wire      rd_en_i,
  output payload_t rd_data_o,
  output logic     full_o,
  output logic     empty_o
);

  // storage, no reset
  payload_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       do_wr;
  logic                       do_rd;

  // wrap at DEPTH, not at a power of two
  function automatic logic [$clog2(DEPTH)-1:0] ptr_inc(input logic [$clog2(DEPTH)-1:0] p);
    if (p == DEPTH - 1) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // illegal accesses dropped
  assign do_wr = wr_en_i && !full_o;
  assign do_rd = rd_en_i && !empty_o;

  assign full_o  = (count_q == DEPTH);
  assign empty_o = (count_q == '0);

  // head shown combinationally
  assign rd_data_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_rd) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop keeps count
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/csr_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_loader import spmm_pkg::*; (
  input  wire                      clk,
  input  wire                      rst_i,
  // batch handshake
  input  wire                      h_valid_i,
  input  wire col_idx_array_t      col_idx_i,
  input  wire value_array_t        value_i,
  input  wire node_info_array_t    node_info_i,
  input  wire weight_array_t       weight_i,
  output logic                     h_ready_o,
  input  wire                      batch_done_i,
  // row fifo write side
  output logic [H_ROWS-1:0]        wr_en_o,
  output h_entry_t                 wr_entry_o,
  // to engine
  output weight_array_t            weight_o,
  output node_info_array_t         node_info_o,
  output logic                     start_o
);

  // latched batch
  col_idx_array_t   col_q;
  value_array_t     value_q;
  node_info_array_t node_q;
  weight_array_t    weight_q;

  // control
  logic                       busy_q;
  logic                       walk_q;
  logic                       empty_done_q;
  logic [ROW_IDX_WIDTH-1:0]   row_q;
  logic [ROW_LEN_WIDTH-1:0]   cnt_q;
  logic [$clog2(NNZ_MAX)-1:0] slot_q;

  logic      accept;
  logic      done;
  logic      row_end;
  row_pick_t pick;
  row_pick_t first_pick;

  ////////////////////////////////////////////////////////////
  // handshake and busy state
  ////////////////////////////////////////////////////////////
  assign h_ready_o = !busy_q;
  assign accept    = h_valid_i && h_ready_o;

  // batch without flagged rows finishes here
  assign first_pick = find_row(node_q, '0, 1'b0);
  assign done       = batch_done_i || empty_done_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      col_q    <= col_idx_i;
      value_q  <= value_i;
      node_q   <= node_info_i;
      weight_q <= weight_i;
    end
  end

  assign weight_o    = weight_q;
  assign node_info_o = node_q;

  ////////////////////////////////////////////////////////////
  // nonzero distribution
  ////////////////////////////////////////////////////////////
  // slots hold flagged rows only, in row order
  assign pick    = find_row(node_q, row_q, 1'b1);
  assign row_end = (node_q[pick.row].row_len == cnt_q + 1'b1);

  assign wr_entry_o.col   = col_q[slot_q];
  assign wr_entry_o.value = value_q[slot_q];

  // one row fifo per cycle
  always_comb begin
    wr_en_o = '0;
    if (walk_q && pick.found) begin
      wr_en_o[pick.row] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q       <= 1'b0;
      start_o      <= 1'b0;
      walk_q       <= 1'b0;
      empty_done_q <= 1'b0;
      row_q        <= '0;
      cnt_q        <= '0;
      slot_q       <= '0;
    end else begin
      start_o      <= accept;
      empty_done_q <= start_o && !first_pick.found;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
      // walk begins the cycle after start
      if (start_o) begin
        walk_q <= 1'b1;
        row_q  <= '0;
        cnt_q  <= '0;
        slot_q <= '0;
      end else if (walk_q) begin
        if (!pick.found) begin
          walk_q <= 1'b0;
        end else begin
          slot_q <= slot_q + 1'b1;
          if (row_end) begin
            // next row starts fresh
            row_q <= pick.row + 1'b1;
            cnt_q <= '0;
          end else begin
            row_q <= pick.row;
            cnt_q <= cnt_q + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spmm_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_engine import spmm_pkg::*; (
  input  wire                          clk,
  input  wire                          rst_i,
  input  wire                          start_i,
  input  wire weight_array_t           weight_i,
  input  wire node_info_array_t        node_info_i,
  // row fifo read side
  input  wire h_entry_t [H_ROWS-1:0]   rd_entry_i,
  input  wire [H_ROWS-1:0]             empty_i,
  output logic [H_ROWS-1:0]            rd_en_o,
  // result queue
  output logic                         push_o,
  output row_result_t                  result_o,
  input  wire                          full_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ROW,
    S_MAC,
    S_PUSH
  } state_t;

  state_t                              state_q;
  logic [ROW_IDX_WIDTH-1:0]            row_q;
  logic [ROW_LEN_WIDTH-1:0]            cnt_q;
  logic [W_COLS-1:0][ACC_WIDTH-1:0]    acc_q;
  logic [W_COLS-1:0][2*DATA_WIDTH-1:0] prod;

  row_pick_t                pick;
  h_entry_t                 entry;
  logic [ROW_IDX_WIDTH-1:0] last_row;
  logic [ROW_IDX_WIDTH-1:0] push_row;
  logic                     zero_len;
  logic                     pop;
  logic                     zero_push;
  logic                     row_push;

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////
  // next flagged row, length zero included
  assign pick     = find_row(node_info_i, row_q, 1'b0);
  assign zero_len = (node_info_i[pick.row].row_len == '0);
  assign entry    = rd_entry_i[row_q];

  // highest flagged row carries last
  always_comb begin
    last_row = '0;
    for (int r = 0; r < H_ROWS; r++) begin
      if (node_info_i[r].flag) begin
        last_row = ROW_IDX_WIDTH'(r);
      end
    end
  end

  // value times W[col][j], unsigned
  always_comb begin
    for (int j = 0; j < W_COLS; j++) begin
      prod[j] = entry.value * weight_i[entry.col][j];
    end
  end

  // pop only with data present
  assign pop = (state_q == S_MAC) && !empty_i[row_q];

  always_comb begin
    rd_en_o        = '0;
    rd_en_o[row_q] = pop;
  end

  // zero row goes straight out, acc already clear
  assign zero_push = (state_q == S_ROW) && pick.found && zero_len && !full_i;
  assign row_push  = (state_q == S_PUSH) && !full_i;
  assign push_o    = zero_push || row_push;
  assign push_row  = (state_q == S_PUSH) ? row_q : pick.row;

  always_comb begin
    result_o.row  = push_row;
    result_o.acc  = acc_q;
    result_o.last = (push_row == last_row);
  end

  ////////////////////////////////////////////////////////////
  // row sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      row_q   <= '0;
      cnt_q   <= '0;
      acc_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q <= S_ROW;
            row_q   <= '0;
            acc_q   <= '0;
          end
        end
        S_ROW: begin
          if (!pick.found) begin
            // nothing flagged
            state_q <= S_IDLE;
          end else if (zero_len) begin
            // stall here while queue full
            if (!full_i) begin
              row_q <= pick.row + 1'b1;
              if (pick.row == last_row) begin
                state_q <= S_IDLE;
              end
            end
          end else begin
            row_q   <= pick.row;
            cnt_q   <= '0;
            state_q <= S_MAC;
          end
        end
        S_MAC: begin
          if (pop) begin
            for (int j = 0; j < W_COLS; j++) begin
              acc_q[j] <= acc_q[j] + prod[j];
            end
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q + 1'b1 == node_info_i[row_q].row_len) begin
              state_q <= S_PUSH;
            end
          end
        end
        S_PUSH: begin
          if (!full_i) begin
            acc_q <= '0;
            if (row_q == last_row) begin
              state_q <= S_IDLE;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= S_ROW;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/result_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_queue import spmm_pkg::*; (
  input  wire              clk,
  input  wire              rst_i,
  // from engine
  input  wire              push_i,
  input  wire row_result_t result_i,
  output logic             full_o,
  // result port
  output logic             out_valid_o,
  input  wire              out_ready_i,
  output row_result_t      out_data_o,
  // back to loader
  output logic             batch_done_o
);

  logic empty;
  logic fire;

  // head held until popped, so data stays put under stall
  fifo #(
    .payload_t (row_result_t),
    .DEPTH     (OUT_DEPTH)
  ) out_fifo_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .wr_en_i   (push_i),
    .wr_data_i (result_i),
    .rd_en_i   (fire),
    .rd_data_o (out_data_o),
    .full_o    (full_o),
    .empty_o   (empty)
  );

  assign out_valid_o = !empty;
  assign fire        = out_valid_o && out_ready_i;

  // one cycle after the last beat leaves
  always_ff @(posedge clk) begin
    if (rst_i) begin
      batch_done_o <= 1'b0;
    end else begin
      batch_done_o <= fire && out_data_o.last;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module scheduler import spmm_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_i,
  // batch in
  input  wire                   h_valid_i,
  input  wire col_idx_array_t   col_idx_i,
  input  wire value_array_t     value_i,
  input  wire node_info_array_t node_info_i,
  input  wire weight_array_t    weight_i,
  output logic                  h_ready_o,
  // results out
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output row_result_t           out_data_o
);

  // row fifo buses
  logic [H_ROWS-1:0]     row_wr_en;
  logic [H_ROWS-1:0]     row_rd_en;
  logic [H_ROWS-1:0]     row_full;
  logic [H_ROWS-1:0]     row_empty;
  h_entry_t              wr_entry;
  h_entry_t [H_ROWS-1:0] row_entry;

  // loader to engine
  weight_array_t         weight;
  node_info_array_t      node_info;
  logic                  start;

  // engine to queue and back
  logic                  push;
  logic                  queue_full;
  row_result_t           result;
  logic                  batch_done;

  ////////////////////////////////////////////////////////////
  // loader
  ////////////////////////////////////////////////////////////
  csr_loader loader_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .h_valid_i    (h_valid_i),
    .col_idx_i    (col_idx_i),
    .value_i      (value_i),
    .node_info_i  (node_info_i),
    .weight_i     (weight_i),
    .h_ready_o    (h_ready_o),
    .batch_done_i (batch_done),
    .wr_en_o      (row_wr_en),
    .wr_entry_o   (wr_entry),
    .weight_o     (weight),
    .node_info_o  (node_info),
    .start_o      (start)
  );

  // one fifo per row of H, shared write data
  for (genvar r = 0; r < H_ROWS; r++) begin : gen_row_fifo
    fifo #(
      .payload_t (h_entry_t),
      .DEPTH     (DOT_SIZE)
    ) row_fifo_inst (
      .clk       (clk),
      .rst_i     (rst_i),
      .wr_en_i   (row_wr_en[r]),
      .wr_data_i (wr_entry),
      .rd_en_i   (row_rd_en[r]),
      .rd_data_o (row_entry[r]),
      .full_o    (row_full[r]),
      .empty_o   (row_empty[r])
    );
  end

  ////////////////////////////////////////////////////////////
  // engine and output
  ////////////////////////////////////////////////////////////
  spmm_engine engine_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .start_i     (start),
    .weight_i    (weight),
    .node_info_i (node_info),
    .rd_entry_i  (row_entry),
    .empty_i     (row_empty),
    .rd_en_o     (row_rd_en),
    .push_o      (push),
    .result_o    (result),
    .full_i      (queue_full)
  );

  result_queue queue_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .push_i       (push),
    .result_i     (result),
    .full_o       (queue_full),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_data_o   (out_data_o),
    .batch_done_o (batch_done)
  );

endmodule

`default_nettype wire

// ==== verif/scheduler_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module scheduler_sva import spmm_pkg::*; (
  input wire                   clk,
  input wire                   rst_i,
  input wire                   h_valid_i,
  input wire                   h_ready_o,
  input wire node_info_array_t node_info_i,
  input wire                   out_valid_o,
  input wire                   out_ready_i,
  input wire row_result_t      out_data_o,
  input wire [H_ROWS-1:0]      row_wr_en,
  input wire [H_ROWS-1:0]      row_rd_en,
  input wire [H_ROWS-1:0]      row_full,
  input wire [H_ROWS-1:0]      row_empty,
  input wire                   push,
  input wire                   queue_full
);

  // assertion failures so far
  int err_cnt = 0;

  // nonzeros that a batch actually uses
  function automatic int flagged_nnz(input node_info_array_t n);
    int sum;
    sum = 0;
    for (int r = 0; r < H_ROWS; r++) begin
      if (n[r].flag) begin
        sum += n[r].row_len;
      end
    end
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////
  // fifo legality
  ////////////////////////////////////////////////////////////
  row_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
    (row_wr_en & row_full) == '0)
    else begin
      $error("row fifo written while full");
      err_cnt++;
    end

  row_no_underflow: assert property (@(posedge clk) disable iff (rst_i)
    (row_rd_en & row_empty) == '0)
    else begin
      $error("row fifo read while empty");
      err_cnt++;
    end

  queue_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
    push |-> !queue_full)
    else begin
      $error("result queue pushed while full");
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // port protocol
  ////////////////////////////////////////////////////////////
  // head must not move under stall
  out_held: assert property (@(posedge clk) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else begin
      $error("out_data_o changed while stalled");
      err_cnt++;
    end

  batch_legal: assert property (@(posedge clk) disable iff (rst_i)
    h_valid_i && h_ready_o |-> flagged_nnz(node_info_i) <= NNZ_MAX)
    else begin
      $error("accepted batch uses more than NNZ_MAX nonzeros");
      err_cnt++;
    end

  busy_while_out: assert property (@(posedge clk) disable iff (rst_i)
    out_valid_o |-> !h_ready_o)
    else begin
      $error("h_ready_o high while results pending");
      err_cnt++;
    end

endmodule

`default_nettype wire

// ==== verif/scheduler_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scheduler_tb
  import spmm_pkg::*;
();

  localparam logic [31:0] SEED           = 32'h24fa_f535;
  // 1 + 1 + 1 + 3 + 40 batches over all tests
  localparam int          NUM_BATCHES    = 46;
  localparam int          TIMEOUT_CYCLES = 60 * NUM_BATCHES + 100;

  logic             clk;
  logic             rst_i;
  logic             h_valid_i;
  col_idx_array_t   col_idx_i;
  value_array_t     value_i;
  node_info_array_t node_info_i;
  weight_array_t    weight_i;
  logic             h_ready_o;
  logic             out_valid_o;
  logic             out_ready_i;
  row_result_t      out_data_o;

  row_result_t exp_q [$];
  string       cur_test;
  logic [31:0] rng;
  logic [31:0] rng_bp;
  logic        bp_en;
  logic        batch_open;
  int          test_errs;
  int          total_errs;
  int          sva_seen;
  int          rows_seen;
  int          pass_cnt;
  int          fail_cnt;
  int          cycles;

  scheduler scheduler_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .h_valid_i   (h_valid_i),
    .col_idx_i   (col_idx_i),
    .value_i     (value_i),
    .node_info_i (node_info_i),
    .weight_i    (weight_i),
    .h_ready_o   (h_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  bind scheduler scheduler_sva sva_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .h_valid_i   (h_valid_i),
    .h_ready_o   (h_ready_o),
    .node_info_i (node_info_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .row_wr_en   (row_wr_en),
    .row_rd_en   (row_rd_en),
    .row_full    (row_full),
    .row_empty   (row_empty),
    .push        (push),
    .queue_full  (queue_full)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic node_info_t make_info(input int len, input logic flag);
    node_info_t n;
    n.row_len = ROW_LEN_WIDTH'(len);
    n.flag    = flag;
    return n;
  endfunction

  // expected beats in row order, slots consumed by flagged rows only
  function automatic int ref_rows(input col_idx_array_t c, input value_array_t v,
                                  input node_info_array_t n, input weight_array_t w,
                                  output row_result_t [H_ROWS-1:0] rows);
    int slot;
    int cnt;
    int last_r;
    int acc;
    slot   = 0;
    cnt    = 0;
    last_r = -1;
    rows   = '0;
    for (int r = 0; r < H_ROWS; r++) begin
      if (n[r].flag) begin
        last_r = r;
      end
    end
    for (int r = 0; r < H_ROWS; r++) begin
      if (n[r].flag) begin
        rows[cnt].row = ROW_IDX_WIDTH'(r);
        for (int j = 0; j < W_COLS; j++) begin
          acc = 0;
          for (int k = 0; k < n[r].row_len; k++) begin
            acc += int'(v[slot + k]) * int'(w[c[slot + k]][j]);
          end
          rows[cnt].acc[j] = ACC_WIDTH'(acc);
        end
        rows[cnt].last = (r == last_r);
        slot += n[r].row_len;
        cnt++;
      end
    end
    return cnt;
  endfunction

  task automatic note_error();
    test_errs++;
    total_errs++;
  endtask

  // deterministic slots and weights for the fixed batches
  task automatic fill_fixed(output col_idx_array_t c, output value_array_t v,
                            output weight_array_t w);
    for (int s = 0; s < NNZ_MAX; s++) begin
      c[s] = COL_IDX_WIDTH'((s * 3 + 1) % DOT_SIZE);
      v[s] = DATA_WIDTH'(s * 29 + 11);
    end
    for (int d = 0; d < DOT_SIZE; d++) begin
      for (int j = 0; j < W_COLS; j++) begin
        w[d][j] = DATA_WIDTH'(d * 40 + j * 17 + 3);
      end
    end
  endtask

  // legal random batch, at least one flagged row
  task automatic build_random(output col_idx_array_t c, output value_array_t v,
                              output node_info_array_t n, output weight_array_t w);
    int   left;
    int   len;
    logic any;
    left = NNZ_MAX;
    any  = 1'b0;
    for (int s = 0; s < NNZ_MAX; s++) begin
      rng  = xorshift32(rng);
      c[s] = COL_IDX_WIDTH'(rng[15:0] % DOT_SIZE);
      v[s] = rng[31:24];
    end
    for (int d = 0; d < DOT_SIZE; d++) begin
      for (int j = 0; j < W_COLS; j++) begin
        rng     = xorshift32(rng);
        w[d][j] = rng[15:8];
      end
    end
    for (int r = 0; r < H_ROWS; r++) begin
      rng = xorshift32(rng);
      len = int'(rng[7:0]) % (DOT_SIZE + 1);
      // roughly three rows in four flagged
      if (rng[11:10] != 2'b00) begin
        if (len > left) begin
          len = left;
        end
        left -= len;
        any   = 1'b1;
        n[r]  = make_info(len, 1'b1);
      end else begin
        n[r] = make_info(len, 1'b0);
      end
    end
    if (!any) begin
      n[int'(rng[18:16]) % H_ROWS].flag = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // batch driver and test framing
  ////////////////////////////////////////////////////////////
  task automatic send_batch(input col_idx_array_t c, input value_array_t v,
                            input node_info_array_t n, input weight_array_t w);
    row_result_t [H_ROWS-1:0] rows;
    int                       cnt;
    cnt = ref_rows(c, v, n, w, rows);
    for (int i = 0; i < cnt; i++) begin
      exp_q.push_back(rows[i]);
    end
    @(posedge clk);
    #1;
    h_valid_i   = 1'b1;
    col_idx_i   = c;
    value_i     = v;
    node_info_i = n;
    weight_i    = w;
    // ready is a register output, stable from negedge to the edge
    @(negedge clk);
    while (!h_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    h_valid_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
    rows_seen = 0;
    sva_seen  = scheduler_inst.sva_inst.err_cnt;
  endtask

  task automatic end_test();
    while (exp_q.size() != 0 || !h_ready_o) begin
      @(negedge clk);
    end
    // idle gap catches duplicated beats
    repeat (4) @(negedge clk);
    // bound assertion failures during this test
    test_errs  += scheduler_inst.sva_inst.err_cnt - sva_seen;
    total_errs += scheduler_inst.sva_inst.err_cnt - sva_seen;
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s: pass, %0d rows checked", cur_test, rows_seen);
    end else begin
      fail_cnt++;
      $display("test %s: fail, %0d errors over %0d rows", cur_test, test_errs, rows_seen);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checkers
  ////////////////////////////////////////////////////////////
  // beat seen at negedge transfers on the next edge
  always @(negedge clk) begin : compare_beats
    row_result_t exp_row;
    if (!rst_i && out_valid_o && out_ready_i) begin
      rows_seen++;
      assert (exp_q.size() > 0) else begin
        $display("%s: a result beat for row %0d arrived with no row expected",
                 cur_test, out_data_o.row);
        note_error();
      end
      if (exp_q.size() > 0) begin
        exp_row = exp_q.pop_front();
        assert (out_data_o == exp_row) else begin
          $display("Error: %s row %0d expected %h actual %h",
                   cur_test, exp_row.row, exp_row, out_data_o);
          note_error();
        end
      end
    end
  end

  // ready low from acceptance until the last beat leaves
  always @(negedge clk) begin
    if (rst_i) begin
      batch_open = 1'b0;
    end else begin
      if (batch_open) begin
        assert (!h_ready_o) else begin
          $display("%s: h_ready_o rose before the last beat of the batch", cur_test);
          note_error();
        end
      end
      if (out_valid_o && out_ready_i && out_data_o.last) begin
        batch_open = 1'b0;
      end
      if (h_valid_i && h_ready_o) begin
        batch_open = 1'b1;
      end
    end
  end

  // random stall on the result port
  always @(posedge clk) begin
    #1;
    if (bp_en) begin
      rng_bp      = xorshift32(rng_bp);
      out_ready_i = rng_bp[4];
    end else begin
      out_ready_i = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d rows still expected", cycles, exp_q.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    col_idx_array_t   c;
    value_array_t     v;
    node_info_array_t n;
    weight_array_t    w;
    rst_i       = 1'b1;
    h_valid_i   = 1'b0;
    col_idx_i   = '0;
    value_i     = '0;
    node_info_i = '0;
    weight_i    = '0;
    out_ready_i = 1'b1;
    bp_en       = 1'b0;
    batch_open  = 1'b0;
    rng         = SEED;
    rng_bp      = xorshift32(SEED);
    test_errs   = 0;
    total_errs  = 0;
    sva_seen    = 0;
    rows_seen   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    cycles      = 0;
    cur_test    = "reset";
    repeat (2) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // idle port state, then one small batch under the ready monitor
    start_test("reset_and_ready");
    @(negedge clk);
    assert (h_ready_o === 1'b1) else begin
      $display("Error: %s h_ready_o expected 1 actual %b", cur_test, h_ready_o);
      note_error();
    end
    assert (out_valid_o === 1'b0) else begin
      $display("Error: %s out_valid_o expected 0 actual %b", cur_test, out_valid_o);
      note_error();
    end
    fill_fixed(c, v, w);
    n    = '0;
    n[1] = make_info(2, 1'b1);
    send_batch(c, v, n, w);
    end_test();

    // every row flagged, 2+1+3+1+1 slots
    start_test("all_flagged");
    fill_fixed(c, v, w);
    n[0] = make_info(2, 1'b1);
    n[1] = make_info(1, 1'b1);
    n[2] = make_info(3, 1'b1);
    n[3] = make_info(1, 1'b1);
    n[4] = make_info(1, 1'b1);
    send_batch(c, v, n, w);
    end_test();

    // unflagged rows carry lengths that must be ignored
    start_test("skip_and_zero");
    n[0] = make_info(2, 1'b1);
    n[1] = make_info(3, 1'b0);
    n[2] = make_info(0, 1'b1);
    n[3] = make_info(4, 1'b0);
    n[4] = make_info(3, 1'b1);
    send_batch(c, v, n, w);
    end_test();

    start_test("back_pressure");
    @(negedge clk);
    bp_en = 1'b1;
    for (int b = 0; b < 3; b++) begin
      build_random(c, v, n, w);
      send_batch(c, v, n, w);
    end
    end_test();
    @(negedge clk);
    bp_en = 1'b0;

    start_test("random_stream");
    for (int b = 0; b < 40; b++) begin
      build_random(c, v, n, w);
      send_batch(c, v, n, w);
    end
    end_test();

    $display("tests passed: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
             pass_cnt, fail_cnt, total_errs, scheduler_inst.sva_inst.err_cnt);
    if (fail_cnt == 0 && total_errs == 0 && scheduler_inst.sva_inst.err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/spmm_pkg.sv
verilog/fifo.sv
verilog/csr_loader.sv
verilog/spmm_engine.sv
verilog/result_queue.sv
verilog/scheduler.sv
verif/scheduler_sva.sv
verif/scheduler_tb.sv

// ==== Bender.yml ====
package:
  name: spmm_scheduler

sources:
  # package first, then leaf modules, then the top level
  - verilog/spmm_pkg.sv
  - verilog/fifo.sv
  - verilog/csr_loader.sv
  - verilog/spmm_engine.sv
  - verilog/result_queue.sv
  - verilog/scheduler.sv
  - target: simulation
    files:
      - verif/scheduler_sva.sv
      - verif/scheduler_tb.sv
